//--- common/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // Major opcodes handled by the core.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // ALU operation, equal to funct3 of OP and OP-IMM.
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_e;

    // Branch condition, funct3 of BRANCH.
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {
        BR_NEVER,
        BR_ALWAYS,
        BR_COND,
        BR_COND_INV
    } branch_op_e;

    localparam logic [31:0] nop_instr = 32'h0000_0013; // ADDI x0, x0, 0.

endpackage

//--- common/rv32_pipe_pkg.sv
package rv32_pipe_pkg;

    // ALU operand source, shared by both operand selects.
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_PC,
        SRC_ZERO
    } alu_src_e;

endpackage

//--- decode/rv32_control_unit.sv
`timescale 1ns/100ps

module rv32_control_unit
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
(
    input  logic [31:0] instr,
    output logic        valid,
    output imm_fmt_e    imm_fmt,
    output alu_op_e     alu_op,
    output logic        alu_sub_sra,
    output alu_src_e    alu_src1,
    output alu_src_e    alu_src2,
    output branch_op_e  branch_op,
    output logic        branch_pc_src,
    output logic        rd_write
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes_rd;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        valid         = 1'b1;
        imm_fmt       = IMM_NONE;
        alu_op        = ALU_ADD;
        alu_sub_sra   = 1'b0;
        alu_src1      = SRC_REG;
        alu_src2      = SRC_IMM;
        branch_op     = BR_NEVER;
        branch_pc_src = 1'b0;
        writes_rd     = 1'b1;

        case (instr[6:0])
            OPC_LUI: begin
                imm_fmt  = IMM_U;
                alu_src1 = SRC_ZERO;
            end
            OPC_AUIPC: begin
                imm_fmt  = IMM_U;
                alu_src1 = SRC_PC;
            end
            OPC_JAL: begin
                imm_fmt   = IMM_J;
                alu_src1  = SRC_PC; // Link is pc + 0, plus four in execute.
                alu_src2  = SRC_ZERO;
                branch_op = BR_ALWAYS;
            end
            OPC_JALR: begin
                imm_fmt       = IMM_I;
                alu_src1      = SRC_PC;
                alu_src2      = SRC_ZERO;
                branch_op     = BR_ALWAYS;
                branch_pc_src = 1'b1; // Target from rs1.
                valid         = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                imm_fmt   = IMM_B;
                alu_op    = alu_op_e'(funct3); // Carries the condition to execute.
                alu_src2  = SRC_REG;
                branch_op = funct3[0] ? BR_COND_INV : BR_COND;
                writes_rd = 1'b0;
                valid     = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
            end
            OPC_OP_IMM: begin
                imm_fmt = IMM_I;
                alu_op  = alu_op_e'(funct3);
                if (funct3 == ALU_SLL) begin
                    valid = (funct7 == 7'h00);
                end else if (funct3 == ALU_SR) begin
                    alu_sub_sra = instr[30];
                    valid       = (funct7 == 7'h00) || (funct7 == 7'h20);
                end
            end
            OPC_OP: begin
                alu_op      = alu_op_e'(funct3);
                alu_src2    = SRC_REG;
                alu_sub_sra = instr[30];
                valid       = (funct7 == 7'h00) ||
                              ((funct7 == 7'h20) && (funct3 == ALU_ADD || funct3 == ALU_SR));
            end
            default: valid = 1'b0;
        endcase

        // Unknown encodings have no effect.
        if (!valid) begin
            imm_fmt     = IMM_NONE;
            alu_sub_sra = 1'b0;
            branch_op   = BR_NEVER;
            writes_rd   = 1'b0;
        end

        rd_write = writes_rd && (instr[11:7] != 5'd0); // x0 never retires.
    end

endmodule

//--- decode/rv32_imm_mux.sv
`timescale 1ns/100ps

module rv32_imm_mux
    import rv32_isa_pkg::*;
(
    input  imm_fmt_e    imm_fmt,
    input  logic [31:0] instr,
    output logic [31:0] imm_value
);

    always_comb begin
        case (imm_fmt)
            IMM_I:   imm_value = {{20{instr[31]}}, instr[31:20]};
            IMM_S:   imm_value = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm_value = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            IMM_U:   imm_value = {instr[31:12], 12'd0};
            IMM_J:   imm_value = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            default: imm_value = 32'd0;
        endcase
    end

endmodule

//--- decode/rv32_regs.sv
`timescale 1ns/100ps

module rv32_regs (
    input  logic        clk,
    input  logic        stall,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        rd_write,
    input  logic [31:0] rd_value,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rd_write && rd != 5'd0) begin
            regs[rd] <= rd_value;
        end
    end

    // Read returns the value before a same-edge write.
    always_ff @(posedge clk) begin
        if (!stall) begin
            rs1_value <= (rs1 == 5'd0) ? 32'd0 : regs[rs1];
            rs2_value <= (rs2 == 5'd0) ? 32'd0 : regs[rs2];
        end
    end

endmodule

//--- decode/rv32_decode.sv
`timescale 1ns/100ps

module rv32_decode
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic [4:0]  wb_rd,
    input  logic        wb_write,
    input  logic [31:0] wb_value,
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [4:0]  rs1_unreg,
    output logic [4:0]  rs2_unreg,
    output alu_op_e     alu_op,
    output logic        alu_sub_sra,
    output alu_src_e    alu_src1,
    output alu_src_e    alu_src2,
    output branch_op_e  branch_op,
    output logic        branch_pc_src,
    output logic [4:0]  rd_out,
    output logic        rd_write_out,
    output logic [31:0] pc_out,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value,
    output logic [31:0] imm_value
);

    logic [4:0]  rd;
    logic        valid;
    imm_fmt_e    dec_imm_fmt;
    alu_op_e     dec_alu_op;
    logic        dec_alu_sub_sra;
    alu_src_e    dec_alu_src1;
    alu_src_e    dec_alu_src2;
    branch_op_e  dec_branch_op;
    logic        dec_branch_pc_src;
    logic        dec_rd_write;
    logic [31:0] dec_imm_value;

    assign rs1_unreg = instr[19:15];
    assign rs2_unreg = instr[24:20];
    assign rd        = instr[11:7];

    rv32_regs i_regs (
        .clk       (clk),
        .stall     (stall),
        .rs1       (rs1_unreg),
        .rs2       (rs2_unreg),
        .rd        (wb_rd),
        .rd_write  (wb_write),
        .rd_value  (wb_value),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    rv32_control_unit i_control_unit (
        .instr         (instr),
        .valid         (valid),
        .imm_fmt       (dec_imm_fmt),
        .alu_op        (dec_alu_op),
        .alu_sub_sra   (dec_alu_sub_sra),
        .alu_src1      (dec_alu_src1),
        .alu_src2      (dec_alu_src2),
        .branch_op     (dec_branch_op),
        .branch_pc_src (dec_branch_pc_src),
        .rd_write      (dec_rd_write)
    );

    rv32_imm_mux i_imm_mux (
        .imm_fmt   (dec_imm_fmt),
        .instr     (instr),
        .imm_value (dec_imm_value)
    );

    // ============================================================
    // Decode register
    // ============================================================

    // A stalled instruction waits in fetch, so execute gets a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_write_out <= 1'b0;
            branch_op    <= BR_NEVER;
        end else if (stall || flush || !valid) begin
            rd_write_out <= 1'b0;
            branch_op    <= BR_NEVER;
        end else begin
            rd_write_out <= dec_rd_write;
            branch_op    <= dec_branch_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            alu_op        <= dec_alu_op;
            alu_sub_sra   <= dec_alu_sub_sra;
            alu_src1      <= dec_alu_src1;
            alu_src2      <= dec_alu_src2;
            branch_pc_src <= dec_branch_pc_src;
            rd_out        <= rd;
            pc_out        <= pc;
            imm_value     <= dec_imm_value;
        end
    end

endmodule

//--- verilog/rv32_fetch.sv
`timescale 1ns/100ps

module rv32_fetch
    import rv32_isa_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic [31:0] branch_target,
    output logic [31:0] instr_addr,
    input  logic [31:0] instr_data,
    output logic [31:0] pc,
    output logic [31:0] instr
);

    logic [31:0] fetch_pc;

    assign instr_addr = fetch_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= RESET_PC;
            instr    <= nop_instr;
        end else if (flush) begin
            fetch_pc <= branch_target; // Redirect.
            instr    <= nop_instr;     // Drop the word fetched behind the branch.
        end else if (!stall) begin
            fetch_pc <= fetch_pc + 32'd4;
            instr    <= instr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc <= fetch_pc;
        end
    end

endmodule

//--- verilog/rv32_execute.sv
`timescale 1ns/100ps

module rv32_execute
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  alu_op_e     alu_op,
    input  logic        alu_sub_sra,
    input  alu_src_e    alu_src1,
    input  alu_src_e    alu_src2,
    input  branch_op_e  branch_op,
    input  logic        branch_pc_src,
    input  logic [4:0]  rd,
    input  logic        rd_write,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_value,
    input  logic [31:0] rs2_value,
    input  logic [31:0] imm_value,
    output logic        branch_taken,
    output logic [31:0] branch_target,
    output logic [4:0]  wb_rd,
    output logic        wb_write,
    output logic [31:0] wb_value,
    output logic [31:0] retire_pc
);

    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] sra_value;
    logic [31:0] alu_result;
    logic [31:0] result;
    logic        cond;

    function automatic logic [31:0] operand(input alu_src_e src, input logic [31:0] reg_value,
                                            input logic [31:0] imm, input logic [31:0] pc_value);
        case (src)
            SRC_REG: return reg_value;
            SRC_IMM: return imm;
            SRC_PC:  return pc_value;
            default: return 32'd0;
        endcase
    endfunction

    assign op1 = operand(alu_src1, rs1_value, imm_value, pc);
    assign op2 = operand(alu_src2, rs2_value, imm_value, pc);

    // ============================================================
    // ALU
    // ============================================================

    assign sra_value = $signed(op1) >>> op2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = alu_sub_sra ? op1 - op2 : op1 + op2;
            ALU_SLL:  alu_result = op1 << op2[4:0];
            ALU_SLT:  alu_result = {31'd0, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_result = {31'd0, op1 < op2};
            ALU_XOR:  alu_result = op1 ^ op2;
            ALU_SR:   alu_result = alu_sub_sra ? sra_value : op1 >> op2[4:0];
            ALU_OR:   alu_result = op1 | op2;
            default:  alu_result = op1 & op2;
        endcase
    end

    // Link adder, the ALU gives pc + 0 for jumps.
    assign result = (branch_op == BR_ALWAYS) ? alu_result + 32'd4 : alu_result;

    // ============================================================
    // Branch unit
    // ============================================================

    always_comb begin
        case (br_cond_e'(alu_op))
            F3_BEQ, F3_BNE: cond = (rs1_value == rs2_value);
            F3_BLT, F3_BGE: cond = ($signed(rs1_value) < $signed(rs2_value));
            default:        cond = (rs1_value < rs2_value);
        endcase

        case (branch_op)
            BR_ALWAYS:   branch_taken = 1'b1;
            BR_COND:     branch_taken = cond;
            BR_COND_INV: branch_taken = !cond;
            default:     branch_taken = 1'b0;
        endcase
    end

    assign branch_target = branch_pc_src ? (rs1_value + imm_value) & ~32'd1
                                         : pc + imm_value;

    // Writeback and retire register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_write <= 1'b0;
        end else begin
            wb_write <= rd_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd     <= rd;
        wb_value  <= result;
        retire_pc <= pc;
    end

endmodule

//--- verilog/rv32_hazard.sv
`timescale 1ns/100ps

module rv32_hazard (
    input  logic [4:0] rs1_unreg,
    input  logic [4:0] rs2_unreg,
    input  logic [4:0] ex_rd,
    input  logic [4:0] wb_rd,
    input  logic       ex_write,
    input  logic       wb_write,
    input  logic       branch_taken,
    output logic       stall,
    output logic       flush
);

    // Source still waits on a result from one later stage.
    function automatic logic raw_hit(input logic [4:0] rs, input logic [4:0] rd,
                                     input logic write);
        return write && (rs != 5'd0) && (rs == rd);
    endfunction

    // A taken branch overrides the stall since it flushes the waiting instruction.
    assign stall = (raw_hit(rs1_unreg, ex_rd, ex_write) || raw_hit(rs1_unreg, wb_rd, wb_write) ||
                    raw_hit(rs2_unreg, ex_rd, ex_write) || raw_hit(rs2_unreg, wb_rd, wb_write)) &&
                   !branch_taken;
    assign flush = branch_taken;

endmodule

//--- verilog/rv32_core.sv
`timescale 1ns/100ps

module rv32_core
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] instr_addr,
    input  logic [31:0] instr_data,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_value
);

    logic        stall;
    logic        flush;
    logic [31:0] fd_pc;
    logic [31:0] fd_instr;
    logic [4:0]  rs1_unreg;
    logic [4:0]  rs2_unreg;
    alu_op_e     alu_op;
    logic        alu_sub_sra;
    alu_src_e    alu_src1;
    alu_src_e    alu_src2;
    branch_op_e  branch_op;
    logic        branch_pc_src;
    logic [4:0]  ex_rd;
    logic        ex_write;
    logic [31:0] ex_pc;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] imm_value;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [4:0]  wb_rd;
    logic        wb_write;
    logic [31:0] wb_value;

    // The retire port is the writeback register.
    assign retire_valid = wb_write;
    assign retire_rd    = wb_rd;
    assign retire_value = wb_value;

    rv32_fetch #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .branch_target (branch_target),
        .instr_addr    (instr_addr),
        .instr_data    (instr_data),
        .pc            (fd_pc),
        .instr         (fd_instr)
    );

    rv32_decode i_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .wb_rd         (wb_rd),
        .wb_write      (wb_write),
        .wb_value      (wb_value),
        .pc            (fd_pc),
        .instr         (fd_instr),
        .rs1_unreg     (rs1_unreg),
        .rs2_unreg     (rs2_unreg),
        .alu_op        (alu_op),
        .alu_sub_sra   (alu_sub_sra),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .branch_op     (branch_op),
        .branch_pc_src (branch_pc_src),
        .rd_out        (ex_rd),
        .rd_write_out  (ex_write),
        .pc_out        (ex_pc),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .imm_value     (imm_value)
    );

    rv32_hazard i_hazard (
        .rs1_unreg    (rs1_unreg),
        .rs2_unreg    (rs2_unreg),
        .ex_rd        (ex_rd),
        .wb_rd        (wb_rd),
        .ex_write     (ex_write),
        .wb_write     (wb_write),
        .branch_taken (branch_taken),
        .stall        (stall),
        .flush        (flush)
    );

    rv32_execute i_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .alu_op        (alu_op),
        .alu_sub_sra   (alu_sub_sra),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .branch_op     (branch_op),
        .branch_pc_src (branch_pc_src),
        .rd            (ex_rd),
        .rd_write      (ex_write),
        .pc            (ex_pc),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .imm_value     (imm_value),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_rd         (wb_rd),
        .wb_write      (wb_write),
        .wb_value      (wb_value),
        .retire_pc     (retire_pc)
    );

endmodule

//--- tb/rv32_core_tb.sv
`timescale 1ns/100ps

module rv32_core_tb
    import rv32_isa_pkg::*;
();

    localparam logic [31:0] RESET_PC     = 32'h0000_0000;
    localparam int          PROG_WORDS   = 48;
    localparam int          MAX_CYCLES   = 8 * PROG_WORDS + 20;
    localparam int          DRAIN_CYCLES = 12;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;

    logic [31:0] imem [0:63];      // Instruction memory model.
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_value [$];
    integer      seed;
    int          cycle_count = 0;

    always #50 clk = ~clk;

    rv32_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    // ============================================================
    // Instruction encoders with operands in assembler order
    // ============================================================

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opcode, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Unmapped or unknown addresses read as NOP.
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if ($isunknown(addr) || addr[31:8] != 24'd0) begin
            return nop_instr;
        end
        return imem[addr[7:2]];
    endfunction

    task automatic put_word(input logic [31:0] addr, input logic [31:0] word);
        imem[addr[7:2]] = word;
    endtask

    task automatic expect_retire(input logic [31:0] pc, input logic [4:0] rd,
                                 input logic [31:0] value);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_value.push_back(value);
    endtask

    task automatic load_program();
        logic [31:0] draw;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [31:0] x1_value;
        logic [31:0] poison;
        int          i;
        draw     = $random(seed);
        imm_a    = draw[11:0];
        draw     = $random(seed);
        imm_b    = draw[11:0];
        x1_value = {{20{imm_a[11]}}, imm_a};
        poison   = i_type(OPC_OP_IMM, ALU_ADD, 5'd19, 5'd0, 12'h7FF); // Must never retire.
        for (i = 0; i < 64; i++) begin
            imem[i] = nop_instr;
        end

        // Immediate formats with the first two from the seeded draws.
        put_word(32'h00, i_type(OPC_OP_IMM, ALU_ADD, 5'd1, 5'd0, imm_a));
        expect_retire(32'h00, 5'd1, x1_value);
        put_word(32'h04, i_type(OPC_OP_IMM, ALU_XOR, 5'd2, 5'd1, imm_b));
        expect_retire(32'h04, 5'd2, x1_value ^ {{20{imm_b[11]}}, imm_b});
        put_word(32'h08, u_type(OPC_LUI, 5'd3, 20'h12345));
        expect_retire(32'h08, 5'd3, 32'h1234_5000);
        put_word(32'h0C, u_type(OPC_AUIPC, 5'd4, 20'h00001));
        expect_retire(32'h0C, 5'd4, 32'h0000_100C);
        put_word(32'h10, i_type(OPC_OP_IMM, ALU_ADD, 5'd5, 5'd0, 12'hFFB)); // -5.
        expect_retire(32'h10, 5'd5, 32'hFFFF_FFFB);
        put_word(32'h14, i_type(OPC_OP_IMM, ALU_ADD, 5'd6, 5'd0, 12'd12));
        expect_retire(32'h14, 5'd6, 32'd12);

        // Dependent register ALU chain.
        put_word(32'h18, r_type(7'h00, ALU_ADD, 5'd7, 5'd5, 5'd6));
        expect_retire(32'h18, 5'd7, 32'd7);
        put_word(32'h1C, r_type(7'h20, ALU_ADD, 5'd8, 5'd7, 5'd5));
        expect_retire(32'h1C, 5'd8, 32'd12);
        put_word(32'h20, r_type(7'h00, ALU_SLL, 5'd9, 5'd8, 5'd6));
        expect_retire(32'h20, 5'd9, 32'h0000_C000);
        put_word(32'h24, r_type(7'h00, ALU_SLT, 5'd10, 5'd5, 5'd9));
        expect_retire(32'h24, 5'd10, 32'd1);
        put_word(32'h28, r_type(7'h00, ALU_SLTU, 5'd11, 5'd5, 5'd9));
        expect_retire(32'h28, 5'd11, 32'd0);
        put_word(32'h2C, r_type(7'h00, ALU_XOR, 5'd12, 5'd9, 5'd5));
        expect_retire(32'h2C, 5'd12, 32'hFFFF_3FFB);
        put_word(32'h30, r_type(7'h00, ALU_SR, 5'd13, 5'd12, 5'd10));
        expect_retire(32'h30, 5'd13, 32'h7FFF_9FFD);
        put_word(32'h34, r_type(7'h20, ALU_SR, 5'd14, 5'd12, 5'd10));
        expect_retire(32'h34, 5'd14, 32'hFFFF_9FFD);
        put_word(32'h38, r_type(7'h00, ALU_OR, 5'd15, 5'd13, 5'd3));
        expect_retire(32'h38, 5'd15, 32'h7FFF_DFFD);
        put_word(32'h3C, r_type(7'h00, ALU_AND, 5'd16, 5'd15, 5'd12));
        expect_retire(32'h3C, 5'd16, 32'h7FFF_1FF9);

        // Neither a write to x0 nor an undefined word retires.
        put_word(32'h40, i_type(OPC_OP_IMM, ALU_ADD, 5'd0, 5'd6, 12'd5));
        put_word(32'h44, 32'h0000_0000);
        put_word(32'h48, r_type(7'h00, ALU_ADD, 5'd17, 5'd0, 5'd6));
        expect_retire(32'h48, 5'd17, 32'd12);

        // Each branch kind taken and then not taken.
        put_word(32'h4C, b_type(F3_BEQ, 5'd6, 5'd8, 13'd12));
        put_word(32'h50, poison);
        put_word(32'h54, poison);
        put_word(32'h58, b_type(F3_BEQ, 5'd6, 5'd5, 13'd8));
        put_word(32'h5C, i_type(OPC_OP_IMM, ALU_ADD, 5'd18, 5'd0, 12'd1));
        expect_retire(32'h5C, 5'd18, 32'd1);
        put_word(32'h60, b_type(F3_BNE, 5'd6, 5'd5, 13'd12));
        put_word(32'h64, poison);
        put_word(32'h68, poison);
        put_word(32'h6C, b_type(F3_BNE, 5'd6, 5'd8, 13'd8));
        put_word(32'h70, i_type(OPC_OP_IMM, ALU_ADD, 5'd18, 5'd18, 12'd2));
        expect_retire(32'h70, 5'd18, 32'd3);
        put_word(32'h74, b_type(F3_BLT, 5'd5, 5'd6, 13'd12));
        put_word(32'h78, poison);
        put_word(32'h7C, poison);
        put_word(32'h80, b_type(F3_BLT, 5'd6, 5'd5, 13'd8));
        put_word(32'h84, i_type(OPC_OP_IMM, ALU_ADD, 5'd18, 5'd18, 12'd4));
        expect_retire(32'h84, 5'd18, 32'd7);
        put_word(32'h88, b_type(F3_BGEU, 5'd5, 5'd6, 13'd12));
        put_word(32'h8C, poison);
        put_word(32'h90, poison);
        put_word(32'h94, b_type(F3_BGEU, 5'd6, 5'd5, 13'd8));
        put_word(32'h98, i_type(OPC_OP_IMM, ALU_ADD, 5'd18, 5'd18, 12'd8));
        expect_retire(32'h98, 5'd18, 32'd15);

        // Jumps. JALR target 0xA8 + 17 lands on 0xB8 once bit 0 is cleared.
        put_word(32'h9C, j_type(5'd1, 21'd12));
        expect_retire(32'h9C, 5'd1, 32'h0000_00A0);
        put_word(32'hA0, poison);
        put_word(32'hA4, poison);
        put_word(32'hA8, u_type(OPC_AUIPC, 5'd22, 20'h00000));
        expect_retire(32'hA8, 5'd22, 32'h0000_00A8);
        put_word(32'hAC, i_type(OPC_JALR, 3'b000, 5'd23, 5'd22, 12'd17));
        expect_retire(32'hAC, 5'd23, 32'h0000_00B0);
        put_word(32'hB0, poison);
        put_word(32'hB4, poison);
        put_word(32'hB8, i_type(OPC_OP_IMM, ALU_ADD, 5'd24, 5'd23, 12'd1));
        expect_retire(32'hB8, 5'd24, 32'h0000_00B1);
        put_word(32'hBC, r_type(7'h00, ALU_ADD, 5'd25, 5'd1, 5'd0));
        expect_retire(32'hBC, 5'd25, 32'h0000_00A0);
    endtask

    // ============================================================
    // Checks and reporting
    // ============================================================

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at time %0d ns: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at time %0d ns: %s is x%0d, expected x%0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at time %0d ns: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // Waits for the next retire strobe, sampled at the falling edge.
    task automatic wait_retire();
        @(negedge clk);
        while (!retire_valid) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            stop_with_failure($sformatf("Timeout after %0d cycles waiting for retires",
                                        cycle_count));
        end
    end

    // Memory answers the current fetch address shortly after each edge.
    initial begin
        instr_data = nop_instr;
        forever begin
            @(posedge clk);
            #10;
            instr_data = read_word(instr_addr);
        end
    end

    initial begin
        int k;
        seed  = 32'h673c_1ce0;
        rst_n = 1'b0;
        load_program();

        repeat (5) begin
            @(posedge clk);
            #10;
            check_bit("retire_valid", retire_valid, 1'b0);
            check_word("instr_addr", instr_addr, RESET_PC);
        end
        rst_n = 1'b1;

        for (k = 0; k < exp_pc.size(); k++) begin
            wait_retire();
            if (retire_rd == 5'd0) begin
                stop_with_failure($sformatf("Retire with destination x0 at pc %h", retire_pc));
            end
            check_word("retire_pc", retire_pc, exp_pc[k]);
            check_reg("retire_rd", retire_rd, exp_rd[k]);
            check_word("retire_value", retire_value, exp_value[k]);
        end

        // Only NOPs follow the program.
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (retire_valid) begin
                stop_with_failure($sformatf("Unexpected extra retire at pc %h", retire_pc));
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

//--- compile.f
common/rv32_isa_pkg.sv
common/rv32_pipe_pkg.sv
decode/rv32_control_unit.sv
decode/rv32_imm_mux.sv
decode/rv32_regs.sv
decode/rv32_decode.sv
verilog/rv32_fetch.sv
verilog/rv32_execute.sv
verilog/rv32_hazard.sv
verilog/rv32_core.sv
tb/rv32_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv32_core_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
